//--- run_sim.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_blob_sorting \
	-f vlog.f -o sim_blob_sorting
./obj_dir/sim_blob_sorting 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

//--- sim/blob_patterns.txt
// test header: mode count pause_flag pause_cycle; records: slot x y size (one per line)
// then 18 expected pointers in table order, rank * 6 + slot - 1; first word is the test count
7
0 6 0 0
1 10 20 64
1 11 30 c8
1 12 40 64
2 20 10 50
1 13 50 12c
2 21 18 50
30d4c 30d49 7fff 7fff 7fff 7fff 30d43 30d4f 7fff 7fff 7fff 7fff 30d40 7fff 7fff 7fff 7fff 7fff
0 6 1 9
1 10 20 64
1 11 30 c8
1 12 40 64
2 20 10 50
1 13 50 12c
2 21 18 50
30d4c 30d49 7fff 7fff 7fff 7fff 30d43 30d4f 7fff 7fff 7fff 7fff 30d40 7fff 7fff 7fff 7fff 7fff
1 5 0 0
3 30 22 40
3 31 23 20
3 32 24 30
3 33 25 10
4 40 26 100
7fff 7fff 30d49 30d4c 7fff 7fff 7fff 7fff 30d43 7fff 7fff 7fff 7fff 7fff 30d46 7fff 7fff 7fff
2 3 0 0
5 50 30 5
5 51 80 1
5 52 50 9
7fff 7fff 7fff 7fff 30d43 7fff 7fff 7fff 7fff 7fff 30d46 7fff 7fff 7fff 7fff 7fff 30d40 7fff
3 3 0 0
5 50 30 5
5 51 80 1
5 52 50 9
7fff 7fff 7fff 7fff 30d40 7fff 7fff 7fff 7fff 7fff 30d46 7fff 7fff 7fff 7fff 7fff 30d43 7fff
0 3 0 0
0 60 10 100
7 61 11 200
2 62 12 5
7fff 30d46 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
0 0 0 0
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff

//--- sim/blob_sorting_checker.sv
`timescale 1ns/1ps
`default_nettype none

module blob_sorting_checker (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic pause,
	input wire logic blob_valid,
	input wire logic blob_done,
	input wire logic table_clear,
	input wire logic done
);

	// ranker answers exactly two unpaused cycles after each blob
	assert property (@(posedge clk) disable iff (!arst_n)
		($past(blob_valid && !pause, 2) && $past(!pause)) |-> blob_done)
		else $error("blob_done missing two cycles after blob_valid");

	assert property (@(posedge clk) disable iff (!arst_n)
		$past(blob_valid && !pause) |-> !blob_done)
		else $error("blob_done one cycle after blob_valid");

	assert property (@(posedge clk) disable iff (!arst_n)
		$past(table_clear && !pause) |-> !table_clear)
		else $error("table_clear longer than one cycle");

	assert property (@(posedge clk) disable iff (!arst_n) !(done && blob_valid))
		else $error("done and blob_valid high together");

endmodule

bind blob_sorting_top blob_sorting_checker blob_sorting_checker_i (.*);

`default_nettype wire

//--- sim/tb_blob_sorting.sv
`timescale 1ns/1ps
`default_nettype none

`include "blob_sort_macros.svh"

module tb_blob_sorting import blob_types_pkg::*, sort_pkg::*; ();

	localparam int NUM_ENTRIES = `NUM_SLOTS * `NUM_RANKS;
	localparam int WAIT_LIMIT = 2000; // cycles for any single wait

	logic clk;
	logic arst_n;
	logic enable;
	logic pause;
	logic [1:0] slide_switches;
	blob_count_t blob_count;
	mem_word_t mem_data = '0;
	table_index_t ptr_read_addr;
	mem_addr_t mem_addr;
	logic done;
	blob_ptr_t ptr_read_data;

	mem_word_t pat [0:511]; // pattern words in file order
	mem_word_t mem [mem_addr_t]; // sparse main memory
	blob_ptr_t model_ptr [NUM_ENTRIES];
	sort_key_t model_key [NUM_ENTRIES];

	blob_sorting_top blob_sorting_top_i (
		.clk (clk),
		.arst_n (arst_n),
		.enable (enable),
		.pause (pause),
		.slide_switches (slide_switches),
		.blob_count (blob_count),
		.mem_data (mem_data),
		.ptr_read_addr (ptr_read_addr),
		.mem_addr (mem_addr),
		.done (done),
		.ptr_read_data (ptr_read_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// words nobody wrote still differ from address to address
	function automatic mem_word_t fill_word(mem_addr_t addr);
		return {~addr[13:0], addr};
	endfunction

	always @(posedge clk) begin
		mem_data <= mem.exists(mem_addr) ? mem[mem_addr] : fill_word(mem_addr); // one cycle read
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_ptr(input table_index_t idx, input blob_ptr_t exp, input blob_ptr_t act);
		if (act !== exp) begin
			$display("ERR %0t ptr_read_data entry %0d expected %h actual %h", $time, idx, exp, act);
			stop_with_failure("pointer read back from the table is wrong");
		end
	endtask

	// records: slot, x, y, size words, three memory words each
	task automatic load_memory(input int first, input int count);
		mem_addr_t a;
		mem.delete();
		for (int n = 0; n < count; n++) begin
			a = mem_addr_t'(int'(`BLOB_BASE_ADDR) + `BLOB_WORDS * n);
			mem[a] = {24'h000000, pat[first + 4 * n][7:0]};
			mem[mem_addr_t'(a + 18'd1)] = {pat[first + 4 * n + 1][7:0],
				pat[first + 4 * n + 2][7:0], pat[first + 4 * n + 3][15:0]};
		end
	endtask

	// reference ranking, insertion into each slot's three places
	task automatic build_model(input int first, input int count, input logic [1:0] mode);
		logic [7:0] slot;
		sort_key_t key;
		logic better;
		logic placed;
		int e;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			model_ptr[i] = `EMPTY_PTR;
			model_key[i] = mode[0] ? 16'hffff : 16'h0000; // the mode never prefers it
		end
		for (int n = 0; n < count; n++) begin
			slot = pat[first + 4 * n][7:0];
			key = mode[1] ? {8'h00, pat[first + 4 * n + 2][7:0]} : pat[first + 4 * n + 3][15:0];
			placed = 1'b0;
			if (slot >= 8'd1 && slot <= 8'(`NUM_SLOTS)) begin
				for (int r = 0; r < `NUM_RANKS; r++) begin
					e = r * `NUM_SLOTS + int'(slot) - 1;
					better = mode[0] ? (key < model_key[e]) : (key > model_key[e]);
					if (better && !placed) begin
						for (int s = `NUM_RANKS - 1; s > r; s--) begin
							model_key[e + (s - r) * `NUM_SLOTS] = model_key[e + (s - r - 1) * `NUM_SLOTS];
							model_ptr[e + (s - r) * `NUM_SLOTS] = model_ptr[e + (s - r - 1) * `NUM_SLOTS];
						end
						model_key[e] = key;
						model_ptr[e] = blob_ptr_t'(int'(`BLOB_BASE_ADDR) + `BLOB_WORDS * n);
						placed = 1'b1;
					end
				end
			end
		end
	endtask

	task automatic run_to_done(input logic pause_on, input int pause_at);
		int cyc;
		cyc = 0;
		while (!done) begin
			@(posedge clk);
			cyc++;
			pause <= pause_on && (cyc >= pause_at) && (cyc < pause_at + 3); // three frozen cycles
			if (cyc > WAIT_LIMIT) begin
				stop_with_failure("done never rose");
			end
		end
		pause <= 1'b0;
	endtask

	task automatic stop_run();
		int cyc;
		cyc = 0;
		@(posedge clk);
		enable <= 1'b0;
		while (done) begin
			@(posedge clk);
			cyc++;
			if (cyc > WAIT_LIMIT) begin
				stop_with_failure("done never fell after enable dropped");
			end
		end
	endtask

	// table keeps its contents after enable drops
	task automatic read_table(input int first);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			@(posedge clk);
			ptr_read_addr <= table_index_t'(i);
			@(posedge clk);
			@(posedge clk);
			check_ptr(table_index_t'(i), blob_ptr_t'(pat[first + i]), ptr_read_data);
		end
	endtask

	initial begin
		int pos;
		int num_tests;
		int count;
		int exp_at;
		logic [1:0] mode;
		arst_n <= 1'b0;
		enable <= 1'b0;
		pause <= 1'b0;
		slide_switches <= 2'b00;
		blob_count <= '0;
		ptr_read_addr <= '0;
		$readmemh("sim/blob_patterns.txt", pat);
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		num_tests = pat[0];
		pos = 1;
		for (int t = 0; t < num_tests; t++) begin
			mode = pat[pos][1:0];
			count = pat[pos + 1];
			exp_at = pos + 4 + 4 * count;
			load_memory(pos + 4, count);
			build_model(pos + 4, count, mode);
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				if (model_ptr[i] !== blob_ptr_t'(pat[exp_at + i])) begin
					stop_with_failure($sformatf("test %0d entry %0d in the pattern file breaks the ranking rule", t, i));
				end
			end
			@(posedge clk);
			slide_switches <= mode;
			blob_count <= blob_count_t'(count);
			enable <= 1'b1;
			run_to_done(pat[pos + 2][0], pat[pos + 3]);
			stop_run();
			read_table(exp_at);
			pos = exp_at + NUM_ENTRIES;
		end
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/blob_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "blob_sort_macros.svh"

module blob_fetch import blob_types_pkg::*, sort_pkg::*; (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic enable,
	input wire logic pause,
	input wire logic [1:0] slide_switches,
	input wire blob_count_t blob_count,
	input wire mem_word_t mem_data,
	input wire logic blob_done,
	output mem_addr_t mem_addr,
	output logic table_clear,
	output sort_mode_t sort_mode,
	output logic blob_valid,
	output color_slot_t new_slot,
	output sort_key_t new_key,
	output blob_ptr_t new_ptr,
	output logic done
);

	fetch_state_t state;
	logic phase; // 0 while memory latches the address, 1 when mem_data is valid
	blob_count_t rec_cnt;
	mem_addr_t rec_addr; // word 0 of the current record
	mem_addr_t next_addr;
	color_slot_t cur_slot;

	color_slot_t w0_slot;
	coord_t w1_y;
	blob_size_t w1_size;
	logic slot_ok;
	logic last_rec;
	logic advance;

	assign w0_slot = mem_data[7:0];
	assign w1_y = mem_data[23:16];
	assign w1_size = mem_data[15:0];
	assign slot_ok = (w0_slot != '0) && (w0_slot <= color_slot_t'(`NUM_SLOTS));

	assign next_addr = rec_addr + mem_addr_t'(`BLOB_WORDS);
	assign last_rec = (rec_cnt == blob_count - 16'd1);

	// record finished: skipped slot, or ranker has taken it
	assign advance = ((state == fs_word0) && phase && !slot_ok) ||
		((state == fs_wait_rank) && blob_done);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= fs_idle;
			phase <= 1'b0;
			rec_cnt <= '0;
			rec_addr <= `BLOB_BASE_ADDR;
			mem_addr <= '0;
			table_clear <= 1'b0;
			blob_valid <= 1'b0;
			done <= 1'b0;
			sort_mode <= size_biggest;
		end else if (!pause) begin
			table_clear <= 1'b0;
			blob_valid <= 1'b0;
			if (!enable) begin
				// table keeps its contents, only the sequencer stops
				state <= fs_idle;
				phase <= 1'b0;
				done <= 1'b0;
				mem_addr <= '0;
			end else begin
				case (state)
					fs_idle: begin
						sort_mode <= sort_mode_t'(slide_switches); // held for the whole run
						table_clear <= 1'b1;
						rec_cnt <= '0;
						rec_addr <= `BLOB_BASE_ADDR;
						mem_addr <= `BLOB_BASE_ADDR;
						state <= fs_clear;
					end
					fs_clear: begin
						phase <= 1'b0;
						if (blob_count == '0) begin
							done <= 1'b1;
							state <= fs_done;
						end else begin
							state <= fs_word0;
						end
					end
					fs_word0: begin
						phase <= !phase;
						if (phase && slot_ok) begin
							mem_addr <= rec_addr + mem_addr_t'(1);
							state <= fs_word1;
						end
					end
					fs_word1: begin
						phase <= !phase;
						if (phase) begin
							blob_valid <= 1'b1;
							state <= fs_wait_rank;
						end
					end
					fs_wait_rank: ; // leaves through advance
					fs_done: done <= 1'b1;
					default: state <= fs_idle;
				endcase

				if (advance) begin
					rec_cnt <= rec_cnt + 16'd1;
					rec_addr <= next_addr;
					mem_addr <= next_addr;
					if (last_rec) begin
						done <= 1'b1;
						state <= fs_done;
					end else begin
						state <= fs_word0;
					end
				end
			end
		end
	end

	// blob payload, held steady from blob_valid until the next one
	always_ff @(posedge clk) begin
		if (!pause && (state == fs_word0) && phase && slot_ok) begin
			cur_slot <= w0_slot;
		end
		if (!pause && (state == fs_word1) && phase) begin
			new_slot <= cur_slot;
			new_ptr <= blob_ptr_t'(rec_addr);
			if ((sort_mode == size_biggest) || (sort_mode == size_smallest)) begin
				new_key <= w1_size;
			end else begin
				new_key <= sort_key_t'(w1_y);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/blob_rank_update.sv
`timescale 1ns/1ps
`default_nettype none

module blob_rank_update import sort_pkg::*; (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic pause,
	input wire sort_mode_t sort_mode,
	input wire logic blob_valid,
	input wire sort_key_t new_key,
	input wire sort_key_t [2:0] slot_keys, // rank 0 is the best
	output logic insert_en,
	output rank_t insert_rank,
	output logic blob_done
);

	rank_state_t state;
	rank_t rank_found;

	// first rank that the new key strictly beats
	always_comb begin
		rank_found = rank_none;
		for (int r = $high(slot_keys); r >= 0; r--) begin
			if (key_beats(sort_mode, new_key, slot_keys[r])) begin
				rank_found = rank_t'(r);
			end
		end
	end

	// blob_valid -> rank registered -> insert_en and blob_done
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= rs_idle;
			insert_rank <= rank_none;
			insert_en <= 1'b0;
			blob_done <= 1'b0;
		end else if (!pause) begin
			case (state)
				rs_idle: begin
					insert_en <= 1'b0;
					blob_done <= 1'b0;
					if (blob_valid) begin
						insert_rank <= rank_found;
						state <= rs_found;
					end
				end
				rs_found: begin
					insert_en <= (insert_rank != rank_none); // losers are only acknowledged
					blob_done <= 1'b1;
					state <= rs_write;
				end
				rs_write: begin
					insert_en <= 1'b0;
					blob_done <= 1'b0;
					state <= rs_idle;
				end
				default: state <= rs_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/blob_sort_macros.svh
`ifndef BLOB_SORT_MACROS_SVH
`define BLOB_SORT_MACROS_SVH

// word address of the first blob record written by blob extraction
`define BLOB_BASE_ADDR 18'd200000

// words per blob record: slot word, centroid/size word, spare word
`define BLOB_WORDS 3

// color slots 1..6 are tracked, slot 0 means no color match
`define NUM_SLOTS 6

// best blobs kept per color slot
`define NUM_RANKS 3

// pointer value marking an unused table entry
`define EMPTY_PTR 19'h7fff

`endif

//--- source/blob_sorting_top.sv
`timescale 1ns/1ps
`default_nettype none

module blob_sorting_top import blob_types_pkg::*, sort_pkg::*; (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic enable,
	input wire logic pause,
	input wire logic [1:0] slide_switches,
	input wire blob_count_t blob_count,
	input wire mem_word_t mem_data,
	input wire table_index_t ptr_read_addr,
	output mem_addr_t mem_addr,
	output logic done,
	output blob_ptr_t ptr_read_data
);

	logic table_clear;
	sort_mode_t sort_mode;
	logic blob_valid;
	logic blob_done;
	color_slot_t new_slot;
	sort_key_t new_key;
	blob_ptr_t new_ptr;
	sort_key_t [2:0] slot_keys;
	logic insert_en;
	rank_t insert_rank;

	blob_fetch blob_fetch_i (
		.clk (clk),
		.arst_n (arst_n),
		.enable (enable),
		.pause (pause),
		.slide_switches (slide_switches),
		.blob_count (blob_count),
		.mem_data (mem_data),
		.blob_done (blob_done),
		.mem_addr (mem_addr),
		.table_clear (table_clear),
		.sort_mode (sort_mode),
		.blob_valid (blob_valid),
		.new_slot (new_slot),
		.new_key (new_key),
		.new_ptr (new_ptr),
		.done (done)
	);

	blob_rank_update blob_rank_update_i (
		.clk (clk),
		.arst_n (arst_n),
		.pause (pause),
		.sort_mode (sort_mode),
		.blob_valid (blob_valid),
		.new_key (new_key),
		.slot_keys (slot_keys),
		.insert_en (insert_en),
		.insert_rank (insert_rank),
		.blob_done (blob_done)
	);

	rank_table rank_table_i (
		.clk (clk),
		.arst_n (arst_n),
		.pause (pause),
		.table_clear (table_clear),
		.sort_mode (sort_mode),
		.new_slot (new_slot),
		.insert_en (insert_en),
		.insert_rank (insert_rank),
		.new_key (new_key),
		.new_ptr (new_ptr),
		.ptr_read_addr (ptr_read_addr),
		.slot_keys (slot_keys),
		.ptr_read_data (ptr_read_data)
	);

endmodule

`default_nettype wire

//--- source/blob_types_pkg.sv
`default_nettype none

// main memory and blob record field types
package blob_types_pkg;

	// main memory word address
	typedef logic [17:0] mem_addr_t;

	// main memory data word
	typedef logic [31:0] mem_word_t;

	// table pointer to word 0 of a record
	typedef logic [18:0] blob_ptr_t;

	typedef logic [7:0] color_slot_t; // word 0 bits 7:0
	typedef logic [7:0] coord_t; // x or y centroid
	typedef logic [15:0] blob_size_t; // pixel count, word 1 bits 15:0

	// records left behind by blob extraction
	typedef logic [15:0] blob_count_t;

endpackage

`default_nettype wire

//--- source/rank_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "blob_sort_macros.svh"

module rank_table import blob_types_pkg::*, sort_pkg::*; (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic pause,
	input wire logic table_clear,
	input wire sort_mode_t sort_mode,
	input wire color_slot_t new_slot,
	input wire logic insert_en,
	input wire rank_t insert_rank,
	input wire sort_key_t new_key,
	input wire blob_ptr_t new_ptr,
	input wire table_index_t ptr_read_addr,
	output sort_key_t [`NUM_RANKS-1:0] slot_keys,
	output blob_ptr_t ptr_read_data
);

	localparam int NUM_ENTRIES = `NUM_SLOTS * `NUM_RANKS;

	sort_key_t keys [NUM_ENTRIES];
	blob_ptr_t ptrs [NUM_ENTRIES];

	logic slot_ok;
	table_index_t slot_base;
	table_index_t row_idx [`NUM_RANKS]; // entry of each rank in the current slot

	assign slot_ok = (new_slot != '0) && (new_slot <= color_slot_t'(`NUM_SLOTS));
	assign slot_base = slot_ok ? table_index_t'(new_slot - color_slot_t'(1)) : '0;

	always_comb begin
		for (int r = 0; r < `NUM_RANKS; r++) begin
			row_idx[r] = slot_base + table_index_t'(r * `NUM_SLOTS);
			slot_keys[r] = keys[row_idx[r]];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				keys[i] <= '0;
				ptrs[i] <= `EMPTY_PTR;
			end
		end else if (!pause) begin
			if (table_clear) begin
				for (int i = 0; i < NUM_ENTRIES; i++) begin
					keys[i] <= empty_key(sort_mode);
					ptrs[i] <= `EMPTY_PTR;
				end
			end else if (insert_en) begin
				// ranks below the insert point move down, old rank 2 falls off
				for (int r = 1; r < `NUM_RANKS; r++) begin
					if (rank_t'(r) > insert_rank) begin
						keys[row_idx[r]] <= keys[row_idx[r-1]];
						ptrs[row_idx[r]] <= ptrs[row_idx[r-1]];
					end
				end
				for (int r = 0; r < `NUM_RANKS; r++) begin
					if (rank_t'(r) == insert_rank) begin
						keys[row_idx[r]] <= new_key;
						ptrs[row_idx[r]] <= new_ptr;
					end
				end
			end
		end
	end

	// external read port, one cycle in every state
	always_ff @(posedge clk) begin
		if (ptr_read_addr < table_index_t'(NUM_ENTRIES)) begin
			ptr_read_data <= ptrs[ptr_read_addr];
		end else begin
			ptr_read_data <= `EMPTY_PTR;
		end
	end

endmodule

`default_nettype wire

//--- source/sort_pkg.sv
`default_nettype none

package sort_pkg;

	typedef logic [15:0] sort_key_t; // size, or y zero-extended

	typedef enum logic [1:0] {
		size_biggest = 2'd0,
		size_smallest = 2'd1,
		y_highest = 2'd2,
		y_lowest = 2'd3
	} sort_mode_t;

	typedef logic [1:0] rank_t;
	localparam rank_t rank_none = 2'd3; // new blob does not make the table

	// entry index = rank * 6 + slot - 1
	typedef logic [4:0] table_index_t;

	typedef enum logic [2:0] {
		fs_idle,
		fs_clear,
		fs_word0,
		fs_word1,
		fs_wait_rank,
		fs_done
	} fetch_state_t;

	typedef enum logic [1:0] {
		rs_idle,
		rs_found,
		rs_write
	} rank_state_t;

	function automatic logic prefers_greater(sort_mode_t mode);
		return (mode == size_biggest) || (mode == y_highest);
	endfunction

	// key that the mode never prefers, so an empty entry always loses
	function automatic sort_key_t empty_key(sort_mode_t mode);
		return prefers_greater(mode) ? 16'h0000 : 16'hffff;
	endfunction

	// strict comparison, ties keep the held entry
	function automatic logic key_beats(sort_mode_t mode, sort_key_t cand, sort_key_t held);
		return prefers_greater(mode) ? (cand > held) : (cand < held);
	endfunction

endpackage

`default_nettype wire

//--- vlog.f
+incdir+source
source/blob_types_pkg.sv
source/sort_pkg.sv
source/blob_fetch.sv
source/blob_rank_update.sv
source/rank_table.sv
source/blob_sorting_top.sv
sim/blob_sorting_checker.sv
sim/tb_blob_sorting.sv
